// File: source/ooo_pkg.sv
package ooo_pkg;

    localparam int xlen        = 32;
    localparam int reg_num     = 16;
    localparam int rob_size    = 8;
    localparam int rs_depth    = 4;   // entries per station
    localparam int mult_cycles = 4;   // start to bus request
    localparam int pc_step     = 4;

    typedef logic [3:0]                  reg_idx_t;
    typedef logic [xlen-1:0]             data_t;
    typedef logic [$clog2(rob_size)-1:0] rob_tag_t;

    // instruction word is {opcode, rd, rs1, rs2, imm16}, msb first
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_sll  = 4'h5,
        op_addi = 4'h6,   // rs2 field unused
        op_mul  = 4'h7,
        op_mulh = 4'h8
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll
    } alu_op_t;

    typedef enum logic {
        mult_low,    // product bits 31:0
        mult_high    // product bits 63:32
    } mult_op_t;

endpackage

// File: source/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   inst_req,
    input  logic [31:0]                            inst_data,
    output logic                                   inst_ack,
    output ooo_pkg::reg_idx_t                      rs1_idx,
    output ooo_pkg::reg_idx_t                      rs2_idx,
    input  ooo_pkg::data_t                         rs1_value,
    input  ooo_pkg::data_t                         rs2_value,
    input  logic                                   rs1_busy,
    input  logic                                   rs2_busy,
    input  ooo_pkg::rob_tag_t                      rs1_tag,
    input  ooo_pkg::rob_tag_t                      rs2_tag,
    input  logic [ooo_pkg::rob_size-1:0]           rob_done,
    input  ooo_pkg::data_t [ooo_pkg::rob_size-1:0] rob_value,
    input  logic                                   rob_full,
    input  ooo_pkg::rob_tag_t                      rob_tail,
    output logic                                   alloc,
    output ooo_pkg::reg_idx_t                      alloc_idx,
    output ooo_pkg::data_t                         alloc_npc,
    output logic                                   alu_load,
    output logic                                   mult_load,
    input  logic                                   alu_full,
    input  logic                                   mult_full,
    output ooo_pkg::alu_op_t                       alu_op,
    output ooo_pkg::mult_op_t                      mult_op,
    output logic                                   src1_ready,
    output logic                                   src2_ready,
    output ooo_pkg::data_t                         src1_value,
    output ooo_pkg::data_t                         src2_value,
    output ooo_pkg::rob_tag_t                      src1_tag,
    output ooo_pkg::rob_tag_t                      src2_tag
);
    import ooo_pkg::*;

    opcode_t     opcode;
    reg_idx_t    rd;
    logic [15:0] imm;
    logic        to_mult;   // target station select
    logic        fire;      // dispatch this cycle
    data_t       pc;

    assign opcode  = opcode_t'(inst_data[31:28]);
    assign rd      = inst_data[27:24];
    assign rs1_idx = inst_data[23:20];
    assign rs2_idx = inst_data[19:16];
    assign imm     = inst_data[15:0];

    // opcode to station and operation
    always_comb begin
        to_mult = 1'b0;
        alu_op  = alu_add;
        mult_op = mult_low;
        case (opcode)
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_xor:  alu_op = alu_xor;
            op_sll:  alu_op = alu_sll;
            op_mul:  to_mult = 1'b1;
            op_mulh: begin
                to_mult = 1'b1;
                mult_op = mult_high;
            end
            default: alu_op = alu_add;   // add, addi
        endcase
    end

    // register value, finished rob value, or wait on tag
    always_comb begin
        src1_ready = 1'b1;
        src1_value = rs1_value;
        src1_tag   = rs1_tag;
        if (rs1_busy) begin
            src1_ready = rob_done[rs1_tag];
            src1_value = rob_value[rs1_tag];
        end
    end

    always_comb begin
        src2_ready = 1'b1;
        src2_value = rs2_value;
        src2_tag   = rs2_tag;
        if (opcode == op_addi) begin
            src2_value = {{(xlen-16){imm[15]}}, imm};   // sign-extended imm
        end else if (rs2_busy) begin
            src2_ready = rob_done[rs2_tag];
            src2_value = rob_value[rs2_tag];
        end
    end

    assign fire      = inst_req && !inst_ack && !rob_full && !(to_mult ? mult_full : alu_full);
    assign alloc     = fire;
    assign alloc_idx = rd;
    assign alloc_npc = pc + data_t'(pc_step);
    assign alu_load  = fire && !to_mult;
    assign mult_load = fire && to_mult;

    // ack side of the four-phase handshake, pc count
    always_ff @(posedge clock) begin
        if (reset) begin
            inst_ack <= 1'b0;
            pc       <= '0;
        end else if (fire) begin
            inst_ack <= 1'b1;
            pc       <= alloc_npc;
        end else if (!inst_req) begin
            inst_ack <= 1'b0;   // req seen low
        end
    end

    // ack is registered, so the req behind it is one sample back
    a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(inst_ack) |-> $past(inst_req));

    // a source never waits on the entry it is allocating
    a_no_self_wait: assert property (@(posedge clock) disable iff (reset)
        fire |-> (src1_ready || src1_tag != rob_tail) && (src2_ready || src2_tag != rob_tail));

endmodule

// File: source/register_map.sv
`timescale 1ns/1ps

module register_map (
    input  logic              clock,
    input  logic              reset,
    input  ooo_pkg::reg_idx_t rs1_idx,
    input  ooo_pkg::reg_idx_t rs2_idx,
    output ooo_pkg::data_t    rs1_value,
    output ooo_pkg::data_t    rs2_value,
    output logic              rs1_busy,
    output logic              rs2_busy,
    output ooo_pkg::rob_tag_t rs1_tag,
    output ooo_pkg::rob_tag_t rs2_tag,
    input  logic              alloc,
    input  ooo_pkg::reg_idx_t alloc_idx,
    input  ooo_pkg::rob_tag_t rob_tail,
    input  logic              commit_valid,
    input  ooo_pkg::reg_idx_t commit_idx,
    input  ooo_pkg::data_t    commit_data,
    input  ooo_pkg::rob_tag_t commit_tag
);
    import ooo_pkg::*;

    data_t              regs [reg_num];
    logic [reg_num-1:0] busy;          // renamed to an in-flight tag
    rob_tag_t           tags [reg_num];

    assign rs1_value = regs[rs1_idx];
    assign rs2_value = regs[rs2_idx];
    assign rs1_busy  = busy[rs1_idx];
    assign rs2_busy  = busy[rs2_idx];
    assign rs1_tag   = tags[rs1_idx];
    assign rs2_tag   = tags[rs2_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_idx != '0) begin   // r0 stays zero
                regs[commit_idx] <= commit_data;
                if (tags[commit_idx] == commit_tag) begin
                    busy[commit_idx] <= 1'b0;   // no younger writer
                end
            end
            // later assignment, so alloc beats a same-cycle clear
            if (alloc && alloc_idx != '0) begin
                busy[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc && alloc_idx != '0) begin
            tags[alloc_idx] <= rob_tail;
        end
    end

endmodule

// File: source/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter type payload_t = logic
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              load,
    input  payload_t          payload,
    input  logic              src1_ready,
    input  logic              src2_ready,
    input  ooo_pkg::data_t    src1_value,
    input  ooo_pkg::data_t    src2_value,
    input  ooo_pkg::rob_tag_t src1_tag,
    input  ooo_pkg::rob_tag_t src2_tag,
    input  ooo_pkg::rob_tag_t dest_tag,
    output logic              full,
    input  logic              busy,
    output logic              issue,
    output payload_t          issue_payload,
    output ooo_pkg::data_t    issue_a,
    output ooo_pkg::data_t    issue_b,
    output ooo_pkg::rob_tag_t issue_tag,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::data_t    cdb_value
);
    import ooo_pkg::*;

    typedef logic [$clog2(rs_depth)-1:0] slot_t;

    logic [rs_depth-1:0] valid;
    logic [rs_depth-1:0] rdy1;
    logic [rs_depth-1:0] rdy2;
    payload_t            op   [rs_depth];
    data_t               val1 [rs_depth];
    data_t               val2 [rs_depth];
    rob_tag_t            tag1 [rs_depth];
    rob_tag_t            tag2 [rs_depth];
    rob_tag_t            dest [rs_depth];
    slot_t               age  [rs_depth];   // 0 is youngest, kept dense
    slot_t               free_slot;
    slot_t               sel;
    logic                found;

    assign full = &valid;

    // lowest empty slot
    always_comb begin
        free_slot = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_slot = slot_t'(i);
            end
        end
    end

    // oldest entry with both operands
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] && (!found || age[i] > age[sel])) begin
                found = 1'b1;
                sel   = slot_t'(i);
            end
        end
    end

    assign issue         = found && !busy;
    assign issue_payload = op[sel];
    assign issue_a       = val1[sel];
    assign issue_b       = val2[sel];
    assign issue_tag     = dest[sel];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (valid[i] && !rdy1[i] && cdb_valid && tag1[i] == cdb_tag) begin
                    rdy1[i] <= 1'b1;   // wakeup
                    val1[i] <= cdb_value;
                end
                if (valid[i] && !rdy2[i] && cdb_valid && tag2[i] == cdb_tag) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= cdb_value;
                end
                // older than the issued one moves down, load pushes all up
                if (valid[i]) begin
                    age[i] <= age[i] + slot_t'(load) - slot_t'(issue && age[i] > age[sel]);
                end
            end
            if (issue) begin
                valid[sel] <= 1'b0;
            end
            if (load) begin
                valid[free_slot] <= 1'b1;
                op[free_slot]    <= payload;
                tag1[free_slot]  <= src1_tag;
                tag2[free_slot]  <= src2_tag;
                dest[free_slot]  <= dest_tag;
                age[free_slot]   <= '0;
                // catch a result broadcast in the load cycle
                rdy1[free_slot]  <= src1_ready || (cdb_valid && cdb_tag == src1_tag);
                rdy2[free_slot]  <= src2_ready || (cdb_valid && cdb_tag == src2_tag);
                val1[free_slot]  <= src1_ready ? src1_value : cdb_value;
                val2[free_slot]  <= src2_ready ? src2_value : cdb_value;
            end
        end
    end

    a_no_load_full: assert property (@(posedge clock) disable iff (reset)
        load |-> !full);

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic              clock,
    input  logic              reset,
    input  logic              issue,
    input  ooo_pkg::alu_op_t  op,
    input  ooo_pkg::data_t    a,
    input  ooo_pkg::data_t    b,
    input  ooo_pkg::rob_tag_t tag,
    output logic              busy,
    output logic              req,
    output ooo_pkg::rob_tag_t req_tag,
    output ooo_pkg::data_t    req_value,
    input  logic              grant
);
    import ooo_pkg::*;

    data_t result;

    always_comb begin
        case (op)
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_sll: result = a << b[4:0];   // shift amount from low 5 bits
            default: result = a + b;
        endcase
    end

    assign busy = req && !grant;   // free again in the grant cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            req <= 1'b0;
        end else if (issue) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    // result register, held until granted
    always_ff @(posedge clock) begin
        if (issue) begin
            req_tag   <= tag;
            req_value <= result;
        end
    end

endmodule

// File: source/mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  ooo_pkg::mult_op_t op,
    input  ooo_pkg::data_t    a,
    input  ooo_pkg::data_t    b,
    input  ooo_pkg::rob_tag_t tag,
    output logic              busy,
    output logic              req,
    output ooo_pkg::rob_tag_t req_tag,
    output ooo_pkg::data_t    req_value,
    input  logic              grant
);
    import ooo_pkg::*;

    localparam int step_w = xlen / mult_cycles;   // multiplier bits per step

    typedef logic [$clog2(mult_cycles)-1:0] step_t;
    typedef logic [2*xlen-1:0]              wide_t;

    wide_t    mcand;
    wide_t    mcand_in;
    wide_t    prod;
    wide_t    sum;
    data_t    mplier;
    data_t    mplier_in;
    step_t    count;
    step_t    step;
    logic     running;
    logic     last;
    mult_op_t op_q;

    // first step runs in the start cycle off the raw operands
    assign mcand_in  = start ? wide_t'(a) : mcand;
    assign mplier_in = start ? b : mplier;
    assign step      = start ? '0 : count;
    assign last      = step == step_t'(mult_cycles - 1);
    assign sum       = (start ? wide_t'(0) : prod) + mcand_in * wide_t'(mplier_in[step_w-1:0]);
    assign busy      = running || (req && !grant);

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            req     <= 1'b0;
        end else begin
            if (start || running) begin
                running <= !last;
            end
            if ((start || running) && last) begin
                req <= 1'b1;   // mult_cycles after start
            end else if (grant) begin
                req <= 1'b0;
            end
        end
    end

    // shift-and-add datapath
    always_ff @(posedge clock) begin
        if (start || running) begin
            prod   <= sum;
            mcand  <= mcand_in << step_w;
            mplier <= mplier_in >> step_w;
            count  <= step + step_t'(1);
        end
        if (start) begin
            op_q    <= op;
            req_tag <= tag;
        end
        if ((start || running) && last) begin
            req_value <= (op_q == mult_high) ? sum[2*xlen-1:xlen] : sum[xlen-1:0];
        end
    end

endmodule

// File: source/completion_bus.sv
`timescale 1ns/1ps

module completion_bus (
    input  logic              alu_req,
    input  ooo_pkg::rob_tag_t alu_tag,
    input  ooo_pkg::data_t    alu_value,
    input  logic              mult_req,
    input  ooo_pkg::rob_tag_t mult_tag,
    input  ooo_pkg::data_t    mult_value,
    output logic              alu_grant,
    output logic              mult_grant,
    output logic              cdb_valid,
    output ooo_pkg::rob_tag_t cdb_tag,
    output ooo_pkg::data_t    cdb_value
);

    // fixed priority, multiplier first
    assign mult_grant = mult_req;
    assign alu_grant  = alu_req && !mult_req;   // alu holds its result meanwhile

    assign cdb_valid = alu_req || mult_req;
    assign cdb_tag   = mult_req ? mult_tag : alu_tag;
    assign cdb_value = mult_req ? mult_value : alu_value;

    // at most one winner
    always_comb begin
        a_one_grant: assert #0 (!(alu_grant && mult_grant));
    end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   alloc,
    input  ooo_pkg::reg_idx_t                      alloc_idx,
    input  ooo_pkg::data_t                         alloc_npc,
    output logic                                   rob_full,
    output ooo_pkg::rob_tag_t                      rob_tail,
    output logic [ooo_pkg::rob_size-1:0]           rob_done,
    output ooo_pkg::data_t [ooo_pkg::rob_size-1:0] rob_value,
    input  logic                                   cdb_valid,
    input  ooo_pkg::rob_tag_t                      cdb_tag,
    input  ooo_pkg::data_t                         cdb_value,
    output logic                                   commit_valid,
    output ooo_pkg::reg_idx_t                      commit_idx,
    output ooo_pkg::data_t                         commit_data,
    output ooo_pkg::data_t                         commit_npc,
    output ooo_pkg::rob_tag_t                      commit_tag
);
    import ooo_pkg::*;

    logic [rob_size-1:0]       valid;
    reg_idx_t                  dest [rob_size];
    data_t                     npc  [rob_size];
    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [$clog2(rob_size):0] count;
    logic                      retire;   // done head leaves this cycle

    assign rob_full = count == rob_size;
    assign rob_tail = tail;
    assign retire   = valid[head] && rob_done[head];

    //////////////////////////////////////////////////
    // pointers and status bits
    always_ff @(posedge clock) begin
        if (reset) begin
            valid        <= '0;
            rob_done     <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (cdb_valid) begin
                rob_done[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (alloc) begin
                valid[tail]    <= 1'b1;
                rob_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;   // wraps at rob_size
            end
            count <= count + alloc - retire;
        end
    end

    //////////////////////////////////////////////////
    // entry payload and commit register
    always_ff @(posedge clock) begin
        if (cdb_valid) begin
            rob_value[cdb_tag] <= cdb_value;
        end
        if (alloc) begin
            dest[tail] <= alloc_idx;
            npc[tail]  <= alloc_npc;
        end
        if (retire) begin
            commit_idx  <= dest[head];
            commit_data <= (dest[head] == '0) ? '0 : rob_value[head];   // r0 reports zero
            commit_npc  <= npc[head];
            commit_tag  <= head;
        end
    end

    a_cdb_live_entry: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> valid[cdb_tag]);

endmodule

// File: source/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              inst_req,
    input  logic [31:0]       inst_data,
    output logic              inst_ack,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_idx,
    output ooo_pkg::data_t    commit_data,
    output ooo_pkg::data_t    commit_npc
);
    import ooo_pkg::*;

    // rename read
    reg_idx_t             rs1_idx, rs2_idx;
    data_t                rs1_value, rs2_value;
    logic                 rs1_busy, rs2_busy;
    rob_tag_t             rs1_tag, rs2_tag;

    // rob status toward dispatch
    logic [rob_size-1:0]  rob_done;
    data_t [rob_size-1:0] rob_value;
    logic                 rob_full;
    rob_tag_t             rob_tail;
    logic                 alloc;
    reg_idx_t             alloc_idx;
    data_t                alloc_npc;

    // station load
    logic                 alu_load, mult_load;
    logic                 alu_full, mult_full;
    alu_op_t              alu_op;
    mult_op_t             mult_op;
    logic                 src1_ready, src2_ready;
    data_t                src1_value, src2_value;
    rob_tag_t             src1_tag, src2_tag;

    // issue and bus
    logic                 alu_issue, alu_busy, mult_start, mult_busy;
    alu_op_t              alu_issue_op;
    mult_op_t             mult_issue_op;
    data_t                alu_a, alu_b, mult_a, mult_b;
    rob_tag_t             alu_issue_tag, mult_issue_tag;
    logic                 alu_req, alu_grant, mult_req, mult_grant, cdb_valid;
    rob_tag_t             alu_tag, mult_tag, cdb_tag, commit_tag;
    data_t                alu_value, mult_value, cdb_value;

    //////////////////////////////////////////////////
    // decode, rename
    dispatch_unit dispatch_unit_i (.*);

    register_map register_map_i (.*);

    //////////////////////////////////////////////////
    // execute
    reservation_station #(.payload_t(alu_op_t)) alu_rs (
        .load          (alu_load),
        .payload       (alu_op),
        .dest_tag      (rob_tail),   // entry just allocated
        .full          (alu_full),
        .busy          (alu_busy),
        .issue         (alu_issue),
        .issue_payload (alu_issue_op),
        .issue_a       (alu_a),
        .issue_b       (alu_b),
        .issue_tag     (alu_issue_tag),
        .*
    );

    reservation_station #(.payload_t(mult_op_t)) mult_rs (
        .load          (mult_load),
        .payload       (mult_op),
        .dest_tag      (rob_tail),
        .full          (mult_full),
        .busy          (mult_busy),
        .issue         (mult_start),
        .issue_payload (mult_issue_op),
        .issue_a       (mult_a),
        .issue_b       (mult_b),
        .issue_tag     (mult_issue_tag),
        .*
    );

    alu_unit alu_unit_i (
        .issue     (alu_issue),
        .op        (alu_issue_op),
        .a         (alu_a),
        .b         (alu_b),
        .tag       (alu_issue_tag),
        .busy      (alu_busy),
        .req       (alu_req),
        .req_tag   (alu_tag),
        .req_value (alu_value),
        .grant     (alu_grant),
        .*
    );

    mult_unit mult_unit_i (
        .start     (mult_start),
        .op        (mult_issue_op),
        .a         (mult_a),
        .b         (mult_b),
        .tag       (mult_issue_tag),
        .busy      (mult_busy),
        .req       (mult_req),
        .req_tag   (mult_tag),
        .req_value (mult_value),
        .grant     (mult_grant),
        .*
    );

    //////////////////////////////////////////////////
    // result, in-order commit
    completion_bus completion_bus_i (.*);

    reorder_buffer reorder_buffer_i (.*);

endmodule

// File: test/ooo_core_checks.svh
`ifndef ooo_core_checks_svh
`define ooo_core_checks_svh

//////////////////////////////////////////////////
// commit port compares, one task per field

task automatic check_idx(input ooo_pkg::reg_idx_t got, input ooo_pkg::reg_idx_t exp,
                         input int n);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch at %0t ns: commit %0d idx got %0d, expected %0d",
                 $time, n, got, exp);
    end
endtask

task automatic check_data(input ooo_pkg::data_t got, input ooo_pkg::data_t exp,
                          input int n);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch at %0t ns: commit %0d data got %h, expected %h",
                 $time, n, got, exp);
    end
endtask

task automatic check_npc(input ooo_pkg::data_t got, input ooo_pkg::data_t exp,
                         input int n);
    if (got !== exp) begin
        mismatches++;
        $display("mismatch at %0t ns: commit %0d npc got %h, expected %h",
                 $time, n, got, exp);
    end
endtask

// idle handshake and commit outputs
task automatic check_low(input string name, input logic got);
    if (got !== 1'b0) begin
        mismatches++;
        $display("mismatch at %0t ns: %s is %b with no request sent", $time, name, got);
    end
endtask

`endif

// File: test/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int ack_limit    = 300;    // cycles per handshake phase
    localparam int commit_limit = 3000;   // cycles for the last commits
    localparam int rand_rows    = 40;

    logic        clock;
    logic        reset;
    logic        inst_req;
    logic [31:0] inst_data;
    logic        inst_ack;
    logic        commit_valid;
    reg_idx_t    commit_idx;
    data_t       commit_data;
    data_t       commit_npc;

    logic [31:0] prog [$];       // instruction words in program order
    reg_idx_t    exp_idx [$];    // filled by the reference model
    data_t       exp_data [$];
    data_t       exp_npc [$];
    integer      seed = 32'h5df5_7ab2;
    int          mismatches = 0;
    int          timeouts = 0;
    int          surplus = 0;
    int          commits = 0;
    logic        stalled = 1'b0;  // handshake gave up

    `include "ooo_core_checks.svh"

    ooo_core ooo_core_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // stimulus table and reference model

    task automatic add_row(input opcode_t op, input int rd, input int rs1, input int rs2,
                           input int imm);
        prog.push_back({op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)});
    endtask

    task automatic build_table();
        opcode_t op;
        add_row(op_addi, 1, 0, 0, 100);    // alu ops
        add_row(op_addi, 2, 0, 0, -7);     // negative imm
        add_row(op_add, 3, 1, 2, 0);
        add_row(op_sub, 4, 1, 2, 0);
        add_row(op_and, 5, 1, 2, 0);
        add_row(op_or, 6, 1, 2, 0);
        add_row(op_xor, 7, 1, 2, 0);
        add_row(op_addi, 8, 0, 0, 3);
        add_row(op_sll, 9, 1, 8, 0);
        add_row(op_sll, 9, 9, 2, 0);       // shift by low 5 bits of -7
        add_row(op_addi, 10, 1, 0, 1);     // chain over the bus
        add_row(op_add, 10, 10, 10, 0);
        add_row(op_sub, 11, 10, 1, 0);
        add_row(op_xor, 10, 11, 10, 0);
        add_row(op_mul, 12, 1, 1, 0);      // holds the rob head
        add_row(op_addi, 13, 0, 0, 5);
        add_row(op_add, 14, 13, 13, 0);    // r13 caught off the bus at load
        add_row(op_add, 14, 14, 12, 0);    // r12 done in the rob, not yet committed
        add_row(op_addi, 15, 0, 0, -1);    // product halves
        add_row(op_mul, 3, 15, 15, 0);
        add_row(op_mulh, 4, 15, 15, 0);
        add_row(op_mulh, 5, 15, 1, 0);
        add_row(op_addi, 6, 0, 0, 42);     // younger alu behind multiplies
        add_row(op_addi, 7, 0, 0, 3);
        for (int i = 0; i < 12; i++) begin
            add_row(op_mul, 7, 7, 7, 0);   // dependent chain, fills station then rob
        end
        add_row(op_addi, 0, 1, 0, 5);      // writes to r0
        add_row(op_mul, 0, 1, 1, 0);
        add_row(op_add, 8, 0, 1, 0);
        add_row(op_or, 9, 0, 0, 0);
        for (int i = 0; i < rand_rows; i++) begin
            op = opcode_t'($unsigned($random(seed)) % 9);
            add_row(op, $random(seed) & 15, $random(seed) & 15, $random(seed) & 15,
                    $random(seed) & 16'hffff);
        end
    endtask

    task automatic run_model();
        data_t       regs [reg_num];
        data_t       a;
        data_t       b;
        data_t       r;
        logic [63:0] prod;
        logic [31:0] w;
        for (int i = 0; i < reg_num; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            w    = prog[i];
            a    = regs[w[23:20]];
            b    = regs[w[19:16]];
            prod = {32'b0, a} * {32'b0, b};   // unsigned product
            case (w[31:28])
                op_sub:  r = a - b;
                op_and:  r = a & b;
                op_or:   r = a | b;
                op_xor:  r = a ^ b;
                op_sll:  r = a << b[4:0];
                op_addi: r = a + {{16{w[15]}}, w[15:0]};
                op_mul:  r = prod[31:0];
                op_mulh: r = prod[63:32];
                default: r = a + b;
            endcase
            if (w[27:24] == 4'd0) begin
                r = '0;   // r0 never written
            end else begin
                regs[w[27:24]] = r;
            end
            exp_idx.push_back(w[27:24]);
            exp_data.push_back(r);
            exp_npc.push_back(data_t'((i + 1) * pc_step));
        end
    endtask

    //////////////////////////////////////////////////
    // handshake driver and waits

    task automatic send_inst(input logic [31:0] word, input int n);
        int waited;
        waited = 0;
        while (inst_ack && waited < ack_limit) begin   // previous ack still up
            @(posedge clock);
            #1;
            waited++;
        end
        if (inst_ack) begin
            timeouts++;
            stalled = 1'b1;
            $display("timeout at %0t ns: inst_ack stayed high before row %0d", $time, n);
            return;
        end
        inst_data = word;
        inst_req  = 1'b1;
        waited    = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
        end while (!inst_ack && waited < ack_limit);
        inst_req = 1'b0;
        if (!inst_ack) begin
            timeouts++;
            stalled = 1'b1;
            $display("timeout at %0t ns: row %0d was never acknowledged", $time, n);
        end
    endtask

    task automatic wait_commits();
        int waited;
        waited = 0;
        while (commits < prog.size() && waited < commit_limit) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (commits < prog.size()) begin
            timeouts++;
            $display("timeout at %0t ns: only %0d of %0d instructions committed",
                     $time, commits, prog.size());
        end
        repeat (20) @(posedge clock);   // window for surplus commits
    endtask

    // commit monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (commits < prog.size()) begin
                check_idx(commit_idx, exp_idx[commits], commits);
                check_data(commit_data, exp_data[commits], commits);
                check_npc(commit_npc, exp_npc[commits], commits);
            end else begin
                surplus++;
                $display("error at %0t ns: commit seen after the last instruction", $time);
            end
            commits++;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        reset     = 1'b1;
        inst_req  = 1'b0;
        inst_data = '0;
        build_table();
        run_model();
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (4) begin
            @(posedge clock);
            #1;
            check_low("inst_ack", inst_ack);
            check_low("commit_valid", commit_valid);
        end
        for (int i = 0; i < prog.size(); i++) begin
            if (!stalled) begin
                send_inst(prog[i], i);
            end
        end
        if (!stalled) begin
            wait_commits();
        end
        $display("closing: %0d mismatches, %0d timeouts, %0d surplus, %0d of %0d commits",
                 mismatches, timeouts, surplus, commits, prog.size());
        if (mismatches == 0 && timeouts == 0 && surplus == 0 && commits == prog.size()) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: ooo_core.f
+incdir+test
source/ooo_pkg.sv
source/dispatch_unit.sv
source/register_map.sv
source/reservation_station.sv
source/alu_unit.sv
source/mult_unit.sv
source/completion_bus.sv
source/reorder_buffer.sv
source/ooo_core.sv
test/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - source/ooo_pkg.sv
  - source/dispatch_unit.sv
  - source/register_map.sv
  - source/reservation_station.sv
  - source/alu_unit.sv
  - source/mult_unit.sv
  - source/completion_bus.sv
  - source/reorder_buffer.sv
  - source/ooo_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ooo_core_tb.sv
